/* flist.f */
rtl/fp_pkg.sv
rtl/fp_lzc.sv
rtl/fp_special_case.sv
rtl/fp_align.sv
rtl/fp_mant_addsub.sv
rtl/fp_round_pack.sv
rtl/fp_addsub_top.sv
verification/tb_fp_addsub.sv

/* run_sim.sh */
#!/bin/sh
# build the adder testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_fp_addsub \
    -f flist.f --Mdir obj_dir -o sim_fp_addsub

./obj_dir/sim_fp_addsub > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run_sim: testbench passed"
else
    echo "run_sim: testbench failed"
    exit 1
fi

/* verification/tb_fp_addsub.sv */
`timescale 1ns/1ps
// tb_fp_addsub: directed testbench for the four-stage binary32 adder/subtractor
module tb_fp_addsub;
    import fp_pkg::*;

    localparam int latency   = 4;
    localparam int max_items = 16;
    // limit sits well above the combined length of all tests
    localparam int max_cycles = 400;

    // binary32 operands and results
    localparam logic [31:0] fp_one     = 32'h3f80_0000;
    localparam logic [31:0] fp_two     = 32'h4000_0000;
    localparam logic [31:0] fp_three   = 32'h4040_0000;
    localparam logic [31:0] fp_m_one   = 32'hbf80_0000;
    localparam logic [31:0] fp_1p5     = 32'h3fc0_0000;
    localparam logic [31:0] fp_m_0p25  = 32'hbe80_0000;
    localparam logic [31:0] fp_1p25    = 32'h3fa0_0000;
    localparam logic [31:0] fp_2p5     = 32'h4020_0000;
    localparam logic [31:0] fp_m_2p5   = 32'hc020_0000;
    localparam logic [31:0] fp_5       = 32'h40a0_0000;
    localparam logic [31:0] fp_tiny    = 32'h3380_0000;
    localparam logic [31:0] fp_m_tiny  = 32'hb380_0000;
    localparam logic [31:0] fp_pinf    = 32'h7f80_0000;
    localparam logic [31:0] fp_ninf    = 32'hff80_0000;
    localparam logic [31:0] fp_qnan    = 32'h7fc0_0001;
    localparam logic [31:0] fp_snan    = 32'h7f80_0001;
    localparam logic [31:0] fp_canon   = 32'h7fc0_0000;
    localparam logic [31:0] fp_max     = 32'h7f7f_ffff;
    localparam logic [31:0] fp_denorm  = 32'h0000_0001;
    localparam logic [31:0] fp_pzero   = 32'h0000_0000;
    localparam logic [31:0] fp_nzero   = 32'h8000_0000;

    logic        clk;
    logic        rst;
    logic        valid_in;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  rmode;
    logic [31:0] result;
    logic        overflow;
    logic        underflow;
    logic        inexact;
    logic        invalid;
    logic        valid_out;

    int          errors;
    int          cycles;
    int          n_items;
    int unsigned seed_word;

    // stimulus and expected response per slot
    logic [31:0] item_a     [max_items];
    logic [31:0] item_b     [max_items];
    logic [2:0]  item_rm    [max_items];
    logic        item_vld   [max_items];
    logic [31:0] item_res   [max_items];
    // flag order is overflow, underflow, inexact, invalid
    logic [3:0]  item_flags [max_items];

    fp_addsub_top dut (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .a         (a),
        .b         (b),
        .rmode     (rmode),
        .result    (result),
        .overflow  (overflow),
        .underflow (underflow),
        .inexact   (inexact),
        .invalid   (invalid),
        .valid_out (valid_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic compare_word(input string what, input logic [31:0] expv,
                                input logic [31:0] got);
        if (got !== expv) begin
            errors++;
            $display("ERROR t=%0t %s expected %h got %h", $time, what, expv, got);
        end
    endtask

    task automatic compare_bit(input string what, input logic expv, input logic got);
        if (got !== expv) begin
            errors++;
            $display("ERROR t=%0t %s expected %b got %b", $time, what, expv, got);
        end
    endtask

    task automatic queue_item(input logic [31:0] op_a, input logic [31:0] op_b,
                              input logic [2:0] rm, input logic [31:0] res,
                              input logic [3:0] flags);
        item_a[n_items]     = op_a;
        item_b[n_items]     = op_b;
        item_rm[n_items]    = rm;
        item_vld[n_items]   = 1'b1;
        item_res[n_items]   = res;
        item_flags[n_items] = flags;
        n_items++;
    endtask

    task automatic queue_gap();
        item_vld[n_items]   = 1'b0;
        item_res[n_items]   = '0;
        item_flags[n_items] = '0;
        n_items++;
    endtask

    task automatic check_slot(input int j);
        string tag;
        tag = $sformatf("item %0d", j);
        if (item_vld[j]) begin
            if (valid_out !== 1'b1) begin
                errors++;
                $display("%s: valid_out did not rise %0d cycles after its input (time %0t)",
                         tag, latency, $time);
            end else begin
                compare_word({tag, " result"}, item_res[j], result);
                compare_bit({tag, " overflow"}, item_flags[j][3], overflow);
                compare_bit({tag, " underflow"}, item_flags[j][2], underflow);
                compare_bit({tag, " inexact"}, item_flags[j][1], inexact);
                compare_bit({tag, " invalid"}, item_flags[j][0], invalid);
            end
        end else begin
            compare_bit({tag, " valid_out in gap"}, 1'b0, valid_out);
        end
    endtask

    // drive all queued slots back to back and check each one latency cycles later
    task automatic run_queue();
        for (int k = 0; k < n_items + latency; k++) begin
            @(posedge clk);
            if (k < n_items && item_vld[k]) begin
                valid_in <= 1'b1;
                a        <= item_a[k];
                b        <= item_b[k];
                rmode    <= item_rm[k];
            end else begin
                // operands are noise while valid_in is low
                valid_in <= 1'b0;
                a        <= $urandom;
                b        <= $urandom;
                rmode    <= RNE;
            end
            @(negedge clk);
            if (k >= latency) begin
                check_slot(k - latency);
            end
        end
        n_items = 0;
    endtask

    task automatic reset_state();
        @(negedge clk);
        compare_bit("reset valid_out", 1'b0, valid_out);
        compare_bit("reset overflow", 1'b0, overflow);
        compare_bit("reset underflow", 1'b0, underflow);
        compare_bit("reset inexact", 1'b0, inexact);
        compare_bit("reset invalid", 1'b0, invalid);
        compare_word("reset result", 32'h0, result);
    endtask

    task automatic exact_sums();
        queue_item(fp_one, fp_two, RNE, fp_three, 4'b0000);
        queue_item(fp_three, fp_m_one, RNE, fp_two, 4'b0000);
        queue_item(fp_1p5, fp_m_0p25, RNE, fp_1p25, 4'b0000);
        run_queue();
    endtask

    // 1.0 + 2^-24 sits exactly halfway between 1.0 and the next value up
    task automatic tie_rounding();
        queue_item(fp_one, fp_tiny, RNE, fp_one, 4'b0010);
        queue_item(fp_one, fp_tiny, RTZ, fp_one, 4'b0010);
        queue_item(fp_one, fp_tiny, RDN, fp_one, 4'b0010);
        queue_item(fp_one, fp_tiny, RUP, 32'h3f80_0001, 4'b0010);
        queue_item(fp_one, fp_tiny, RMM, 32'h3f80_0001, 4'b0010);
        queue_item(fp_m_one, fp_m_tiny, RDN, 32'hbf80_0001, 4'b0010);
        queue_item(fp_m_one, fp_m_tiny, RUP, fp_m_one, 4'b0010);
        run_queue();
    endtask

    task automatic special_values();
        queue_item(fp_qnan, fp_one, RNE, fp_qnan, 4'b0000);
        queue_item(fp_snan, fp_one, RNE, 32'h7fc0_0001, 4'b0001);
        queue_item(fp_pinf, fp_ninf, RNE, fp_canon, 4'b0001);
        queue_item(fp_pinf, fp_5, RNE, fp_pinf, 4'b0000);
        run_queue();
    endtask

    task automatic zeros_and_flush();
        queue_item(fp_2p5, fp_m_2p5, RNE, fp_pzero, 4'b0000);
        queue_item(fp_2p5, fp_m_2p5, RDN, fp_nzero, 4'b0000);
        queue_item(fp_denorm, fp_one, RNE, fp_one, 4'b0100);
        queue_item(fp_pzero, fp_nzero, RNE, fp_pzero, 4'b0000);
        queue_item(fp_pzero, fp_nzero, RUP, fp_pzero, 4'b0000);
        queue_item(fp_pzero, fp_nzero, RDN, fp_nzero, 4'b0000);
        run_queue();
    endtask

    task automatic overflow_saturation();
        queue_item(fp_max, fp_max, RNE, fp_pinf, 4'b1010);
        queue_item(fp_max, fp_max, RUP, fp_pinf, 4'b1010);
        queue_item(fp_max, fp_max, RTZ, fp_max, 4'b1010);
        queue_item(fp_max, fp_max, RDN, fp_max, 4'b1010);
        run_queue();
    endtask

    // eight mixed items in consecutive cycles, then an idle cycle, then one more
    task automatic back_to_back();
        queue_item(fp_one, fp_two, RNE, fp_three, 4'b0000);
        queue_item(fp_one, fp_tiny, RUP, 32'h3f80_0001, 4'b0010);
        queue_item(fp_snan, fp_one, RTZ, 32'h7fc0_0001, 4'b0001);
        queue_item(fp_three, fp_m_one, RDN, fp_two, 4'b0000);
        queue_item(fp_pinf, fp_ninf, RMM, fp_canon, 4'b0001);
        queue_item(fp_1p5, fp_m_0p25, RNE, fp_1p25, 4'b0000);
        queue_item(fp_one, fp_tiny, RTZ, fp_one, 4'b0010);
        queue_item(fp_qnan, fp_one, RNE, fp_qnan, 4'b0000);
        queue_gap();
        queue_item(fp_pinf, fp_5, RNE, fp_pinf, 4'b0000);
        run_queue();
    endtask

    initial begin
        seed_word = $urandom(32'h141d);
        errors    = 0;
        cycles    = 0;
        n_items   = 0;
        rst       = 1'b1;
        valid_in  = 1'b0;
        a         = '0;
        b         = '0;
        rmode     = RNE;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        reset_state();
        exact_sums();
        tie_rounding();
        special_values();
        zeros_and_flush();
        overflow_saturation();
        back_to_back();
        $display("tests done after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* rtl/fp_addsub_top.sv */
`timescale 1ns/1ps
// fp_addsub_top: four-stage pipelined binary32 adder/subtractor
module fp_addsub_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_in,
    input  logic [fp_pkg::FP_W-1:0] a,
    input  logic [fp_pkg::FP_W-1:0] b,
    input  logic [fp_pkg::RM_W-1:0] rmode,
    output logic [fp_pkg::FP_W-1:0] result,
    output logic                    overflow,
    output logic                    underflow,
    output logic                    inexact,
    output logic                    invalid,
    output logic                    valid_out
);
    import fp_pkg::*;

    // stage 1 to stage 2
    logic [FP_W-1:0] s_a, s_b, s_special_res;
    logic s_special, s_invalid, s_flushed, s_valid;
    logic [RM_W-1:0] s_rmode;

    // stage 2 to stage 3
    logic l_sign, sticky, sub;
    logic [EXP_W-1:0] l_exp;
    logic [FRAC_W:0] l_frac;
    logic [ALIGN_W-1:0] sm_aligned;
    logic [FP_W-1:0] a_special_res;
    logic a_special, a_invalid, a_flushed, a_valid;
    logic [RM_W-1:0] a_rmode;

    // stage 3 to stage 4
    logic [SUM_W-1:0] raw;
    logic m_sign, m_sticky, m_sub;
    logic [EXP_W-1:0] m_exp;
    logic [FP_W-1:0] m_special_res;
    logic m_special, m_invalid, m_flushed, m_valid;
    logic [RM_W-1:0] m_rmode;

    fp_special_case u_special (
        .clk           (clk),
        .rst           (rst),
        .valid_in      (valid_in),
        .a             (a),
        .b             (b),
        .rmode         (rmode),
        .s_a           (s_a),
        .s_b           (s_b),
        .s_special     (s_special),
        .s_special_res (s_special_res),
        .s_invalid     (s_invalid),
        .s_flushed     (s_flushed),
        .s_rmode       (s_rmode),
        .s_valid       (s_valid)
    );

    fp_align u_align (
        .clk           (clk),
        .rst           (rst),
        .s_a           (s_a),
        .s_b           (s_b),
        .s_special     (s_special),
        .s_special_res (s_special_res),
        .s_invalid     (s_invalid),
        .s_flushed     (s_flushed),
        .s_rmode       (s_rmode),
        .s_valid       (s_valid),
        .l_sign        (l_sign),
        .l_exp         (l_exp),
        .l_frac        (l_frac),
        .sm_aligned    (sm_aligned),
        .sticky        (sticky),
        .sub           (sub),
        .a_special     (a_special),
        .a_special_res (a_special_res),
        .a_invalid     (a_invalid),
        .a_flushed     (a_flushed),
        .a_rmode       (a_rmode),
        .a_valid       (a_valid)
    );

    fp_mant_addsub u_addsub (
        .clk           (clk),
        .rst           (rst),
        .l_sign        (l_sign),
        .l_exp         (l_exp),
        .l_frac        (l_frac),
        .sm_aligned    (sm_aligned),
        .sticky        (sticky),
        .sub           (sub),
        .a_special     (a_special),
        .a_special_res (a_special_res),
        .a_invalid     (a_invalid),
        .a_flushed     (a_flushed),
        .a_rmode       (a_rmode),
        .a_valid       (a_valid),
        .raw           (raw),
        .m_sign        (m_sign),
        .m_exp         (m_exp),
        .m_sticky      (m_sticky),
        .m_sub         (m_sub),
        .m_special     (m_special),
        .m_special_res (m_special_res),
        .m_invalid     (m_invalid),
        .m_flushed     (m_flushed),
        .m_rmode       (m_rmode),
        .m_valid       (m_valid)
    );

    fp_round_pack u_round (
        .clk           (clk),
        .rst           (rst),
        .raw           (raw),
        .m_sign        (m_sign),
        .m_exp         (m_exp),
        .m_sticky      (m_sticky),
        .m_sub         (m_sub),
        .m_special     (m_special),
        .m_special_res (m_special_res),
        .m_invalid     (m_invalid),
        .m_flushed     (m_flushed),
        .m_rmode       (m_rmode),
        .m_valid       (m_valid),
        .result        (result),
        .overflow      (overflow),
        .underflow     (underflow),
        .inexact       (inexact),
        .invalid       (invalid),
        .valid_out     (valid_out)
    );

endmodule

/* rtl/fp_round_pack.sv */
`timescale 1ns/1ps
// fp_round_pack: adder stage 4, normalizes, rounds, saturates and registers the result
module fp_round_pack (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [fp_pkg::SUM_W-1:0] raw,
    input  logic                     m_sign,
    input  logic [fp_pkg::EXP_W-1:0] m_exp,
    input  logic                     m_sticky,
    input  logic                     m_sub,
    input  logic                     m_special,
    input  logic [fp_pkg::FP_W-1:0]  m_special_res,
    input  logic                     m_invalid,
    input  logic                     m_flushed,
    input  logic [fp_pkg::RM_W-1:0]  m_rmode,
    input  logic                     m_valid,
    output logic [fp_pkg::FP_W-1:0]  result,
    output logic                     overflow,
    output logic                     underflow,
    output logic                     inexact,
    output logic                     invalid,
    output logic                     valid_out
);
    import fp_pkg::*;

    logic [SHIFT_W-1:0] lz, shift;
    logic carry, zero_diff, grs, round_up, sat_inf, exp_unf, exp_ovf;
    logic [ALIGN_W-1:0] norm;
    logic [FRAC_W-1:0] frac_n;
    logic [FRAC_W:0] frac_r;
    // two spare bits, the top one flags a negative exponent
    logic [EXP_W+1:0] exp_n, exp_r;
    logic g, r, s;
    logic [FP_W-1:0] res_c;
    logic ovf_c, unf_c, inx_c;

    fp_lzc u_lzc (
        .diff  (raw[ALIGN_W-1:0]),
        .count (lz)
    );

    // add carry shifts right by one, subtraction shifts left by the zero count
    assign carry     = ~m_sub & raw[SUM_W-1];
    assign zero_diff = m_sub & (raw[ALIGN_W-1:0] == '0);
    assign shift     = carry ? '0 : lz;
    assign norm      = carry ? raw[SUM_W-1:1] : raw[ALIGN_W-1:0] << shift;
    assign exp_n     = (EXP_W+2)'(m_exp) + (EXP_W+2)'(carry) - (EXP_W+2)'(shift);

    assign frac_n = norm[ALIGN_W-2 -: FRAC_W];
    assign g      = norm[2];
    assign r      = norm[1];
    assign s      = norm[0] | m_sticky | (carry & raw[0]);
    assign grs    = g | r | s;

    always_comb begin
        case (m_rmode)
            RNE:     round_up = g & (r | s | frac_n[0]);
            RDN:     round_up = m_sign & grs;
            RUP:     round_up = ~m_sign & grs;
            RMM:     round_up = g;
            default: round_up = 1'b0;
        endcase
    end

    // a fraction carry bumps the exponent, which may reach the all-ones code
    assign frac_r  = {1'b0, frac_n} + (FRAC_W+1)'(round_up);
    assign exp_r   = exp_n + (EXP_W+2)'(frac_r[FRAC_W]);
    assign exp_unf = exp_n[EXP_W+1] | (exp_n == '0);
    assign exp_ovf = exp_r >= (EXP_W+2)'(EXP_MAX);

    always_comb begin
        case (m_rmode)
            RNE, RMM: sat_inf = 1'b1;
            RUP:      sat_inf = ~m_sign;
            RDN:      sat_inf = m_sign;
            default:  sat_inf = 1'b0;
        endcase
    end

    always_comb begin
        ovf_c = 1'b0;
        unf_c = m_flushed;
        inx_c = 1'b0;
        if (m_special) begin
            res_c = m_special_res;
        end else if (zero_diff) begin
            res_c = {m_rmode == RDN, {FP_W-1{1'b0}}};
        end else if (exp_unf) begin
            res_c = {m_sign, {FP_W-1{1'b0}}};
            unf_c = 1'b1;
            inx_c = grs;
        end else if (exp_ovf) begin
            // infinity or the largest finite value, by mode and sign
            if (sat_inf) begin
                res_c = {m_sign, EXP_MAX, {FRAC_W{1'b0}}};
            end else begin
                res_c = {m_sign, EXP_MAX_FIN, {FRAC_W{1'b1}}};
            end
            ovf_c = 1'b1;
            inx_c = 1'b1;
        end else begin
            res_c = {m_sign, exp_r[EXP_W-1:0], frac_r[FRAC_W-1:0]};
            inx_c = grs;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result    <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
            inexact   <= 1'b0;
            invalid   <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            result    <= res_c;
            overflow  <= ovf_c;
            underflow <= unf_c;
            inexact   <= inx_c;
            invalid   <= m_invalid;
            valid_out <= m_valid;
        end
    end

endmodule

/* rtl/fp_mant_addsub.sv */
`timescale 1ns/1ps
// fp_mant_addsub: adder stage 3, adds or subtracts the aligned significands
module fp_mant_addsub (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       l_sign,
    input  logic [fp_pkg::EXP_W-1:0]   l_exp,
    input  logic [fp_pkg::FRAC_W:0]    l_frac,
    input  logic [fp_pkg::ALIGN_W-1:0] sm_aligned,
    input  logic                       sticky,
    input  logic                       sub,
    input  logic                       a_special,
    input  logic [fp_pkg::FP_W-1:0]    a_special_res,
    input  logic                       a_invalid,
    input  logic                       a_flushed,
    input  logic [fp_pkg::RM_W-1:0]    a_rmode,
    input  logic                       a_valid,
    output logic [fp_pkg::SUM_W-1:0]   raw,
    output logic                       m_sign,
    output logic [fp_pkg::EXP_W-1:0]   m_exp,
    output logic                       m_sticky,
    output logic                       m_sub,
    output logic                       m_special,
    output logic [fp_pkg::FP_W-1:0]    m_special_res,
    output logic                       m_invalid,
    output logic                       m_flushed,
    output logic [fp_pkg::RM_W-1:0]    m_rmode,
    output logic                       m_valid
);
    import fp_pkg::*;

    logic [ALIGN_W-1:0] l_sig;
    logic [ALIGN_W-1:0] diff_c;

    assign l_sig  = {l_frac, {ALIGN_W-FRAC_W-1{1'b0}}};
    // larger minus smaller never borrows
    assign diff_c = l_sig - sm_aligned;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raw           <= '0;
            m_sign        <= 1'b0;
            m_exp         <= '0;
            m_sticky      <= 1'b0;
            m_sub         <= 1'b0;
            m_special     <= 1'b0;
            m_special_res <= '0;
            m_invalid     <= 1'b0;
            m_flushed     <= 1'b0;
            m_rmode       <= '0;
            m_valid       <= 1'b0;
        end else begin
            raw           <= sub ? {1'b0, diff_c} : {1'b0, l_sig} + {1'b0, sm_aligned};
            m_sign        <= l_sign;
            m_exp         <= l_exp;
            m_sticky      <= sticky;
            m_sub         <= sub;
            m_special     <= a_special;
            m_special_res <= a_special_res;
            m_invalid     <= a_invalid;
            m_flushed     <= a_flushed;
            m_rmode       <= a_rmode;
            m_valid       <= a_valid;
        end
    end

endmodule

/* rtl/fp_align.sv */
`timescale 1ns/1ps
// fp_align: adder stage 2, orders operands by magnitude and aligns the smaller significand
module fp_align (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [fp_pkg::FP_W-1:0]  s_a,
    input  logic [fp_pkg::FP_W-1:0]  s_b,
    input  logic                     s_special,
    input  logic [fp_pkg::FP_W-1:0]  s_special_res,
    input  logic                     s_invalid,
    input  logic                     s_flushed,
    input  logic [fp_pkg::RM_W-1:0]  s_rmode,
    input  logic                     s_valid,
    output logic                     l_sign,
    output logic [fp_pkg::EXP_W-1:0] l_exp,
    output logic [fp_pkg::FRAC_W:0]  l_frac,
    output logic [fp_pkg::ALIGN_W-1:0] sm_aligned,
    output logic                     sticky,
    output logic                     sub,
    output logic                     a_special,
    output logic [fp_pkg::FP_W-1:0]  a_special_res,
    output logic                     a_invalid,
    output logic                     a_flushed,
    output logic [fp_pkg::RM_W-1:0]  a_rmode,
    output logic                     a_valid
);
    import fp_pkg::*;

    logic a_larger, far;
    logic [FP_W-1:0] lg, sm;
    logic [EXP_W-1:0] exp_diff;
    logic [SHIFT_W-1:0] shamt;
    logic [ALIGN_W+MAX_SHIFT-1:0] wide;

    // ties on the exponent go to the larger or equal fraction
    assign a_larger = (s_a[FP_W-2 -: EXP_W] > s_b[FP_W-2 -: EXP_W]) |
                      ((s_a[FP_W-2 -: EXP_W] == s_b[FP_W-2 -: EXP_W]) &
                       (s_a[FRAC_W-1:0] >= s_b[FRAC_W-1:0]));
    assign lg       = a_larger ? s_a : s_b;
    assign sm       = a_larger ? s_b : s_a;
    assign exp_diff = lg[FP_W-2 -: EXP_W] - sm[FP_W-2 -: EXP_W];

    // beyond the shift limit the whole significand lands in sticky
    assign far   = exp_diff > MAX_SHIFT;
    assign shamt = far ? SHIFT_W'(MAX_SHIFT) : exp_diff[SHIFT_W-1:0];
    assign wide  = {1'b1, sm[FRAC_W-1:0], {ALIGN_W-FRAC_W-1{1'b0}}, {MAX_SHIFT{1'b0}}} >> shamt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            l_sign        <= 1'b0;
            l_exp         <= '0;
            l_frac        <= '0;
            sm_aligned    <= '0;
            sticky        <= 1'b0;
            sub           <= 1'b0;
            a_special     <= 1'b0;
            a_special_res <= '0;
            a_invalid     <= 1'b0;
            a_flushed     <= 1'b0;
            a_rmode       <= '0;
            a_valid       <= 1'b0;
        end else begin
            l_sign        <= lg[FP_W-1];
            l_exp         <= lg[FP_W-2 -: EXP_W];
            l_frac        <= {1'b1, lg[FRAC_W-1:0]};
            sm_aligned    <= far ? '0 : wide[ALIGN_W+MAX_SHIFT-1 -: ALIGN_W];
            sticky        <= far | (|wide[MAX_SHIFT-1:0]);
            sub           <= s_a[FP_W-1] ^ s_b[FP_W-1];
            a_special     <= s_special;
            a_special_res <= s_special_res;
            a_invalid     <= s_invalid;
            a_flushed     <= s_flushed;
            a_rmode       <= s_rmode;
            a_valid       <= s_valid;
        end
    end

endmodule

/* rtl/fp_special_case.sv */
`timescale 1ns/1ps
// fp_special_case: adder stage 1, classifies operands and forms the special-case result
module fp_special_case (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_in,
    input  logic [fp_pkg::FP_W-1:0] a,
    input  logic [fp_pkg::FP_W-1:0] b,
    input  logic [fp_pkg::RM_W-1:0] rmode,
    output logic [fp_pkg::FP_W-1:0] s_a,
    output logic [fp_pkg::FP_W-1:0] s_b,
    output logic                    s_special,
    output logic [fp_pkg::FP_W-1:0] s_special_res,
    output logic                    s_invalid,
    output logic                    s_flushed,
    output logic [fp_pkg::RM_W-1:0] s_rmode,
    output logic                    s_valid
);
    import fp_pkg::*;

    logic a_max, b_max, a_zd, b_zd;
    logic a_inf, b_inf, a_qnan, b_qnan, a_snan, b_snan, a_den, b_den;
    logic sp;
    logic [FP_W-1:0] sp_res;

    // exponent all ones or all zeros, then split on the fraction
    assign a_max  = a[FP_W-2 -: EXP_W] == EXP_MAX;
    assign b_max  = b[FP_W-2 -: EXP_W] == EXP_MAX;
    assign a_zd   = a[FP_W-2 -: EXP_W] == '0;
    assign b_zd   = b[FP_W-2 -: EXP_W] == '0;
    assign a_inf  = a_max & ~(|a[FRAC_W-1:0]);
    assign b_inf  = b_max & ~(|b[FRAC_W-1:0]);
    assign a_qnan = a_max & a[QNAN_BIT];
    assign b_qnan = b_max & b[QNAN_BIT];
    assign a_snan = a_max & ~a[QNAN_BIT] & (|a[FRAC_W-1:0]);
    assign b_snan = b_max & ~b[QNAN_BIT] & (|b[FRAC_W-1:0]);
    assign a_den  = a_zd & (|a[FRAC_W-1:0]);
    assign b_den  = b_zd & (|b[FRAC_W-1:0]);

    // priority: qnan, snan, inf pair, single inf, zero pair, single zero
    always_comb begin
        sp     = 1'b1;
        sp_res = '0;
        if (a_qnan) begin
            sp_res = a;
        end else if (b_qnan) begin
            sp_res = b;
        end else if (a_snan) begin
            sp_res = {a[FP_W-1:QNAN_BIT+1], 1'b1, a[QNAN_BIT-1:0]};
        end else if (b_snan) begin
            sp_res = {b[FP_W-1:QNAN_BIT+1], 1'b1, b[QNAN_BIT-1:0]};
        end else if (a_inf & b_inf) begin
            sp_res = (a[FP_W-1] == b[FP_W-1]) ? a : CANON_QNAN;
        end else if (a_inf) begin
            sp_res = a;
        end else if (b_inf) begin
            sp_res = b;
        end else if (a_zd & b_zd) begin
            // opposite-signed zeros give -0 only when rounding down
            if (a[FP_W-1] == b[FP_W-1]) begin
                sp_res = {a[FP_W-1], {FP_W-1{1'b0}}};
            end else begin
                sp_res = {rmode == RDN, {FP_W-1{1'b0}}};
            end
        end else if (a_zd) begin
            sp_res = b;
        end else if (b_zd) begin
            sp_res = a;
        end else begin
            sp = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_a           <= '0;
            s_b           <= '0;
            s_special     <= 1'b0;
            s_special_res <= '0;
            s_invalid     <= 1'b0;
            s_flushed     <= 1'b0;
            s_rmode       <= '0;
            s_valid       <= 1'b0;
        end else begin
            // denormals go on as zero of the same sign
            s_a           <= a_den ? {a[FP_W-1], {FP_W-1{1'b0}}} : a;
            s_b           <= b_den ? {b[FP_W-1], {FP_W-1{1'b0}}} : b;
            s_special     <= sp;
            s_special_res <= sp_res;
            s_invalid     <= a_snan | b_snan | (a_inf & b_inf & (a[FP_W-1] ^ b[FP_W-1]));
            s_flushed     <= a_den | b_den;
            s_rmode       <= rmode;
            s_valid       <= valid_in;
        end
    end

endmodule

/* rtl/fp_lzc.sv */
`timescale 1ns/1ps
// fp_lzc: leading-zero count of the difference, gives the normalization left shift
module fp_lzc (
    input  logic [fp_pkg::ALIGN_W-1:0] diff,
    output logic [fp_pkg::SHIFT_W-1:0] count
);
    import fp_pkg::*;

    // scan upward so the highest set bit decides, all zeros gives ALIGN_W
    always_comb begin
        count = SHIFT_W'(ALIGN_W);
        for (int i = 0; i < ALIGN_W; i++) begin
            if (diff[i]) begin
                count = SHIFT_W'(ALIGN_W - 1 - i);
            end
        end
    end

endmodule

/* rtl/fp_pkg.sv */
// fp_pkg: binary32 field layout, adder datapath widths and rounding-mode codes
package fp_pkg;

    // binary32 word layout
    localparam int FP_W     = 32;
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    localparam int QNAN_BIT = 22;

    // exponent codes, all ones marks infinity or nan
    localparam logic [EXP_W-1:0] EXP_MAX     = 8'hff;
    localparam logic [EXP_W-1:0] EXP_MAX_FIN = 8'hfe;

    localparam logic [FP_W-1:0] CANON_QNAN = 32'h7fc0_0000;

    // hidden bit, fraction, then guard, round and sticky positions
    localparam int ALIGN_W   = FRAC_W + 4;
    localparam int SUM_W     = ALIGN_W + 1;
    localparam int SHIFT_W   = 5;
    localparam int MAX_SHIFT = 24;

    // rounding modes
    localparam int RM_W = 3;
    localparam logic [RM_W-1:0] RNE = 3'd0;
    localparam logic [RM_W-1:0] RTZ = 3'd1;
    localparam logic [RM_W-1:0] RDN = 3'd2;
    localparam logic [RM_W-1:0] RUP = 3'd3;
    localparam logic [RM_W-1:0] RMM = 3'd4;

endpackage
